// File: apbPkg.sv
`default_nettype none

package apbPkg;

	localparam int ApbAddrBits = 4;
	localparam int ApbDataBits = 32;

	typedef struct packed {
		logic psel;
		logic penable;
		logic pwrite;
		logic [ApbAddrBits-1:0] paddr;
		logic [ApbDataBits-1:0] pwdata;
	} apbReq_t;

	typedef struct packed {
		logic [ApbDataBits-1:0] prdata;
		logic pready;
		logic pslverr;
	} apbRsp_t;

	typedef enum logic [ApbAddrBits-1:0] {
		RegCtrl = 4'h0,
		RegBase = 4'h4,
		RegLength = 4'h8,
		RegStatus = 4'hC
	} regAddr_e;

endpackage

`default_nettype wire

// File: audioPkg.sv
`default_nettype none

package audioPkg;

	localparam int WordBits = 128;
	localparam int SampleBits = 16;
	localparam int AddrBits = 22;
	localparam int LengthBits = 16;
	localparam int FifoDepth = 8;
	// SClk cycles per half period of bclk
	localparam int ClkDiv = 4;

	localparam int FifoPtrBits = $clog2(FifoDepth);
	localparam int DivBits = $clog2(ClkDiv);
	// Each channel slot is 32 bclk periods: the delay bit, 16 data bits, then zeros
	localparam int SlotBits = 5;
	localparam int SamplesPerWord = WordBits / SampleBits;
	localparam int PosBits = SlotBits + $clog2(SamplesPerWord);
	localparam int WordSelBits = $clog2(WordBits);

	typedef struct packed {
		logic rd;
		logic [AddrBits-1:0] addr;
	} memReq_t;

	typedef struct packed {
		logic memWait;
		logic ack;
		logic [WordBits-1:0] data;
	} memRsp_t;

	typedef struct packed {
		logic bclk;
		logic lrclk;
		logic sdata;
	} i2sOut_t;

	typedef struct packed {
		logic [AddrBits-1:0] baseAddr;
		logic [LengthBits-1:0] length;
	} playCfg_t;

	typedef enum logic [1:0] {Halted, Fetch, Store, Drain} fetchState_e;
	typedef enum logic [1:0] {Idle, Load, Shift} serState_e;

endpackage

`default_nettype wire

// File: apbRegs.sv
`default_nettype none

module apbRegs
(
	input  logic SClk,
	input  logic reset,
	input  apbPkg::apbReq_t apbReq,
	output apbPkg::apbRsp_t apbRsp,
	output audioPkg::playCfg_t playCfg,
	output logic startPulse,
	output logic stopPulse,
	input  logic fetchDone,
	input  logic serIdle,
	input  logic underrunPulse
);
	import apbPkg::*;
	import audioPkg::*;

	logic access;
	logic writeEn;
	logic mapped;
	logic busy;
	logic done;
	logic underrun;
	regAddr_e regAddr;

	assign access = apbReq.psel && apbReq.penable;
	assign writeEn = access && apbReq.pwrite;
	assign regAddr = regAddr_e'(apbReq.paddr);
	assign mapped = apbReq.paddr inside {RegCtrl, RegBase, RegLength, RegStatus};

	// Command bits of RegCtrl become one-cycle pulses after the access cycle
	always_ff @(posedge SClk)
	begin
		if (reset)
		begin
			playCfg <= '0;
			startPulse <= 1'b0;
			stopPulse <= 1'b0;
		end
		else
		begin
			startPulse <= writeEn && (regAddr == RegCtrl) && apbReq.pwdata[0];
			stopPulse <= writeEn && (regAddr == RegCtrl) && apbReq.pwdata[1];
			if (writeEn && (regAddr == RegBase))
				playCfg.baseAddr <= apbReq.pwdata[AddrBits-1:0];
			if (writeEn && (regAddr == RegLength))
				playCfg.length <= apbReq.pwdata[LengthBits-1:0];
		end
	end

	always_ff @(posedge SClk)
	begin
		if (reset)
		begin
			busy <= 1'b0;
			done <= 1'b0;
			underrun <= 1'b0;
		end
		else
		begin
			// Start has priority since the fetcher is still halted in that cycle
			if (startPulse)
			begin
				busy <= 1'b1;
				done <= 1'b0;
			end
			else if (busy && fetchDone && serIdle)
			begin
				busy <= 1'b0;
				done <= 1'b1;
			end
			if (underrunPulse)
				underrun <= 1'b1;
			else if (writeEn && (regAddr == RegStatus) && apbReq.pwdata[2])
				underrun <= 1'b0;
		end
	end

	always_comb
	begin
		apbRsp.prdata = '0;
		case (regAddr)
			RegBase: apbRsp.prdata = ApbDataBits'(playCfg.baseAddr);
			RegLength: apbRsp.prdata = ApbDataBits'(playCfg.length);
			RegStatus: apbRsp.prdata = ApbDataBits'({underrun, done, busy});
			default: apbRsp.prdata = '0;
		endcase
	end

	assign apbRsp.pready = 1'b1;
	assign apbRsp.pslverr = access && !mapped;

endmodule

`default_nettype wire

// File: sampleFetcher.sv
`default_nettype none

module sampleFetcher
(
	input  logic SClk,
	input  logic reset,
	input  audioPkg::playCfg_t playCfg,
	input  logic startPulse,
	input  logic stopPulse,
	output audioPkg::memReq_t memReq,
	input  audioPkg::memRsp_t memRsp,
	input  logic fifoFull,
	output logic fifoWrite,
	output logic [audioPkg::WordBits-1:0] fifoData,
	input  logic serIdle,
	output logic fetchDone
);
	import audioPkg::*;

	fetchState_e state;
	logic [AddrBits-1:0] nextAddr;
	logic [AddrBits-1:0] openAddr;
	logic [LengthBits-1:0] wordsLeft;
	logic reqOpen;
	logic discard;
	logic newReq;
	logic wordAck;

	// Only one read is outstanding, so a word never arrives for a full FIFO
	assign newReq = (state == Fetch) && !reqOpen && !memRsp.memWait && !fifoFull
		&& (wordsLeft != '0);
	assign memReq.rd = reqOpen || newReq;
	assign memReq.addr = reqOpen ? openAddr : nextAddr;
	assign wordAck = memRsp.ack && memReq.rd && !discard;

	assign fifoWrite = (state == Store);
	assign fetchDone = (state == Halted) || (state == Drain);

	always_ff @(posedge SClk)
	begin
		if (reset)
		begin
			state <= Halted;
			nextAddr <= '0;
			wordsLeft <= '0;
		end
		else if (stopPulse)
			state <= Halted;
		else
		begin
			case (state)
				Halted:
					if (startPulse)
					begin
						state <= Fetch;
						nextAddr <= playCfg.baseAddr;
						wordsLeft <= playCfg.length;
					end
				Fetch:
					if (wordsLeft == '0)
						state <= Drain;
					else if (wordAck)
						state <= Store;
				Store:
				begin
					nextAddr <= nextAddr + 1'b1;
					wordsLeft <= wordsLeft - 1'b1;
					state <= Fetch;
				end
				Drain:
					if (serIdle)
						state <= Halted;
			endcase
		end
	end

	// A read cut short by stop still runs to its ack, and its word is dropped
	always_ff @(posedge SClk)
	begin
		if (reset)
		begin
			reqOpen <= 1'b0;
			discard <= 1'b0;
		end
		else
		begin
			if (memRsp.ack)
				reqOpen <= 1'b0;
			else if (memReq.rd)
				reqOpen <= 1'b1;
			if (memRsp.ack)
				discard <= 1'b0;
			else if (stopPulse && memReq.rd)
				discard <= 1'b1;
		end
	end

	always_ff @(posedge SClk)
	begin
		if (newReq)
			openAddr <= nextAddr;
		if (wordAck && (state == Fetch))
			fifoData <= memRsp.data;
	end

endmodule

`default_nettype wire

// File: sampleFifo.sv
`default_nettype none

module sampleFifo
(
	input  logic SClk,
	input  logic reset,
	input  logic flush,
	input  logic write,
	input  logic [audioPkg::WordBits-1:0] writeData,
	input  logic read,
	output logic [audioPkg::WordBits-1:0] readData,
	output logic full,
	output logic empty
);
	import audioPkg::*;

	logic [WordBits-1:0] mem [FifoDepth];
	logic [FifoPtrBits-1:0] wrPtr;
	logic [FifoPtrBits-1:0] rdPtr;
	logic [FifoPtrBits:0] count;
	logic doWrite;
	logic doRead;

	assign doWrite = write && !full;
	assign doRead = read && !empty;
	assign full = (count == (FifoPtrBits + 1)'(FifoDepth));
	assign empty = (count == '0);
	// Head entry is visible without a read latency
	assign readData = mem[rdPtr];

	always_ff @(posedge SClk)
	begin
		if (reset || flush)
		begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end
		else
		begin
			if (doWrite)
				wrPtr <= wrPtr + 1'b1;
			if (doRead)
				rdPtr <= rdPtr + 1'b1;
			case ({doWrite, doRead})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	always_ff @(posedge SClk)
	begin
		if (doWrite)
			mem[wrPtr] <= writeData;
	end

endmodule

`default_nettype wire

// File: i2sSerializer.sv
`default_nettype none

module i2sSerializer
(
	input  logic SClk,
	input  logic reset,
	input  logic stopPulse,
	input  logic playing,
	input  logic fifoEmpty,
	input  logic [audioPkg::WordBits-1:0] fifoData,
	output logic fifoRead,
	output audioPkg::i2sOut_t i2sOut,
	output logic serIdle,
	output logic underrunPulse
);
	import audioPkg::*;

	serState_e state;
	logic [DivBits-1:0] divCnt;
	logic tick;
	logic bclkFall;
	logic [PosBits-1:0] pos;
	logic [PosBits-1:0] nextPos;
	logic [SlotBits-1:0] dataBit;
	logic [WordSelBits-1:0] bitSel;
	logic [WordBits-1:0] word;

	assign tick = (divCnt == DivBits'(ClkDiv - 1));
	assign bclkFall = tick && i2sOut.bclk;

	// pos counts bclk periods in a word; slot bit 0 is the I2S delay bit
	assign nextPos = pos + 1'b1;
	assign dataBit = nextPos[SlotBits-1:0] - 1'b1;
	assign bitSel = WordSelBits'(nextPos[PosBits-1:SlotBits] * SampleBits + SampleBits - 1
		- dataBit);

	assign fifoRead = (state == Load) && !fifoEmpty;
	assign serIdle = (state == Idle) && fifoEmpty;

	always_ff @(posedge SClk)
	begin
		if (reset || stopPulse)
		begin
			state <= Idle;
			divCnt <= '0;
			pos <= '0;
			i2sOut <= '0;
			underrunPulse <= 1'b0;
		end
		else
		begin
			underrunPulse <= 1'b0;
			if (state != Idle)
				divCnt <= tick ? '0 : divCnt + 1'b1;
			case (state)
				Idle:
					if (!fifoEmpty)
					begin
						state <= Load;
						divCnt <= '0;
						pos <= '0;
					end
				Load:
					if (!fifoEmpty || playing)
					begin
						state <= Shift;
						underrunPulse <= fifoEmpty;
					end
					else
					begin
						state <= Idle;
						divCnt <= '0;
					end
				Shift:
					if (tick)
					begin
						i2sOut.bclk <= !i2sOut.bclk;
						if (bclkFall)
						begin
							pos <= nextPos;
							// Odd samples are the right channel
							i2sOut.lrclk <= nextPos[SlotBits];
							i2sOut.sdata <= (dataBit < SampleBits) ? word[bitSel] : 1'b0;
							if (nextPos == '0)
								state <= Load;
						end
					end
				default: state <= Idle;
			endcase
		end
	end

	// An underrun plays a silent word in place of the missing one
	always_ff @(posedge SClk)
	begin
		if (state == Load)
			word <= fifoEmpty ? '0 : fifoData;
	end

endmodule

`default_nettype wire

// File: i2sPlayer.sv
`default_nettype none

module i2sPlayer
(
	input  logic SClk,
	input  logic reset,
	input  apbPkg::apbReq_t apbReq,
	output apbPkg::apbRsp_t apbRsp,
	output audioPkg::memReq_t memReq,
	input  audioPkg::memRsp_t memRsp,
	output audioPkg::i2sOut_t i2sOut
);
	import audioPkg::*;

	playCfg_t playCfg;
	logic startPulse;
	logic stopPulse;
	logic fetchDone;
	logic serIdle;
	logic underrunPulse;
	logic fifoWrite;
	logic [WordBits-1:0] fifoWriteData;
	logic fifoFull;
	logic fifoEmpty;
	logic fifoRead;
	logic [WordBits-1:0] fifoReadData;

	apbRegs regs (
		.SClk(SClk),
		.reset(reset),
		.apbReq(apbReq),
		.apbRsp(apbRsp),
		.playCfg(playCfg),
		.startPulse(startPulse),
		.stopPulse(stopPulse),
		.fetchDone(fetchDone),
		.serIdle(serIdle),
		.underrunPulse(underrunPulse)
	);

	sampleFetcher fetcher (
		.SClk(SClk),
		.reset(reset),
		.playCfg(playCfg),
		.startPulse(startPulse),
		.stopPulse(stopPulse),
		.memReq(memReq),
		.memRsp(memRsp),
		.fifoFull(fifoFull),
		.fifoWrite(fifoWrite),
		.fifoData(fifoWriteData),
		.serIdle(serIdle),
		.fetchDone(fetchDone)
	);

	sampleFifo fifo (
		.SClk(SClk),
		.reset(reset),
		.flush(stopPulse),
		.write(fifoWrite),
		.writeData(fifoWriteData),
		.read(fifoRead),
		.readData(fifoReadData),
		.full(fifoFull),
		.empty(fifoEmpty)
	);

	i2sSerializer serializer (
		.SClk(SClk),
		.reset(reset),
		.stopPulse(stopPulse),
		.playing(!fetchDone),
		.fifoEmpty(fifoEmpty),
		.fifoData(fifoReadData),
		.fifoRead(fifoRead),
		.i2sOut(i2sOut),
		.serIdle(serIdle),
		.underrunPulse(underrunPulse)
	);

endmodule

`default_nettype wire

// File: i2sPlayer_properties.sv
`default_nettype none

module i2sPlayerProperties
(
	input logic SClk,
	input logic reset,
	input apbPkg::apbReq_t apbReq,
	input audioPkg::memReq_t memReq,
	input audioPkg::memRsp_t memRsp,
	input logic fifoWrite,
	input logic fifoFull
);
	timeunit 1ns;
	timeprecision 1ps;

	int assertFails = 0;

	// A read stays on the port with the same address until its ack
	holdUntilAck: assert property (@(posedge SClk) disable iff (reset)
		memReq.rd && !memRsp.ack |=> memReq.rd && $stable(memReq.addr))
	else
	begin
		assertFails++;
		$error("memory read dropped or changed its address before ack");
	end

	setupThenAccess: assert property (@(posedge SClk) disable iff (reset)
		apbReq.psel && !apbReq.penable |=> apbReq.psel && apbReq.penable)
	else
	begin
		assertFails++;
		$error("APB setup cycle not followed by an access cycle");
	end

	noWriteWhenFull: assert property (@(posedge SClk) disable iff (reset)
		fifoWrite |-> !fifoFull)
	else
	begin
		assertFails++;
		$error("sample FIFO written while full");
	end

endmodule

bind i2sPlayer i2sPlayerProperties propsCheck (
	.SClk(SClk),
	.reset(reset),
	.apbReq(apbReq),
	.memReq(memReq),
	.memRsp(memRsp),
	.fifoWrite(fifoWrite),
	.fifoFull(fifoFull)
);

`default_nettype wire

// File: i2sPlayerTb.sv
`default_nettype none

module i2sPlayerTb;
	timeunit 1ns;
	timeprecision 1ps;

	import apbPkg::*;
	import audioPkg::*;

	typedef struct {
		string name;
		logic [AddrBits-1:0] baseAddr;
		logic [LengthBits-1:0] length;
		int latency;
		int waitCycles;
		bit stall;
	} scenario_t;

	localparam int NumRows = 4;
	localparam int PollLimit = 30000;
	localparam int CycleLimit = 20000;

	// A latency above one word time (2048 cycles) starves the serializer
	scenario_t rows [NumRows] = '{
		'{"short burst", 22'h000100, 16'd3, 2, 0, 1'b0},
		'{"back pressure", 22'h02A000, 16'd12, 9, 5, 1'b0},
		'{"forced underrun", 22'h000200, 16'd2, 2500, 0, 1'b1},
		'{"clean after underrun", 22'h000000, 16'd2, 1, 2, 1'b0}
	};
	regAddr_e regList [4] = '{RegCtrl, RegBase, RegLength, RegStatus};

	logic SClk = 1'b0;
	logic reset = 1'b1;
	apbReq_t apbReq = '0;
	apbRsp_t apbRsp;
	memReq_t memReq;
	memRsp_t memRsp = '0;
	i2sOut_t i2sOut;
	logic bclk;

	int wordErrors = 0;
	int sampleErrors = 0;
	int flagErrors = 0;
	int otherErrors = 0;

	int memLatency = 1;
	int memWaitCycles = 0;
	bit memBusy = 1'b0;
	int latLeft = 0;
	int waitLeft = 0;
	logic [AddrBits-1:0] reqAddr;
	logic rdSample = 1'b0;
	logic [AddrBits-1:0] addrSample;

	int rowId = 0;
	int rxRow = 0;
	int slotBit = 0;
	int rowSampleCnt = 0;
	logic prevLr = 1'b0;
	logic [SampleBits-1:0] shiftReg;
	logic [SampleBits-1:0] rxSamples [$];

	i2sPlayer dut_i (
		.SClk(SClk),
		.reset(reset),
		.apbReq(apbReq),
		.apbRsp(apbRsp),
		.memReq(memReq),
		.memRsp(memRsp),
		.i2sOut(i2sOut)
	);

	assign bclk = i2sOut.bclk;

	always #20 SClk = !SClk;

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic logic [WordBits-1:0] wordAt(input logic [AddrBits-1:0] addr);
		logic [WordBits-1:0] w;
		logic [31:0] s;
		s = 32'd10 + 32'(addr);
		for (int i = 0; i < WordBits / 32; i++)
		begin
			s = xorshift(s);
			w[32*i +: 32] = s;
		end
		return w;
	endfunction

	function automatic logic [SampleBits-1:0] expectedSample(input logic [AddrBits-1:0] base,
		input int idx);
		logic [WordBits-1:0] w;
		w = wordAt(base + AddrBits'(idx / SamplesPerWord));
		return w[SampleBits * (idx % SamplesPerWord) +: SampleBits];
	endfunction

	task automatic checkWord(input string name, input logic [ApbDataBits-1:0] expected,
		input logic [ApbDataBits-1:0] actual);
		if (actual !== expected)
		begin
			wordErrors++;
			$display("[ERROR] %s: expected %h, actual %h", name, expected, actual);
		end
	endtask

	task automatic checkSample(input string name, input logic [SampleBits-1:0] expected,
		input logic [SampleBits-1:0] actual);
		if (actual !== expected)
		begin
			sampleErrors++;
			$display("[ERROR] %s: expected %h, actual %h", name, expected, actual);
		end
	endtask

	task automatic checkFlag(input string name, input logic expected, input logic actual);
		if (actual !== expected)
		begin
			flagErrors++;
			$display("[ERROR] %s: expected %b, actual %b", name, expected, actual);
		end
	endtask

	task automatic finishRun();
		int total;
		total = wordErrors + sampleErrors + flagErrors + otherErrors
			+ dut_i.propsCheck.assertFails;
		$display("Error counts: word %0d, sample %0d, flag %0d, other %0d, assertion %0d",
			wordErrors, sampleErrors, flagErrors, otherErrors, dut_i.propsCheck.assertFails);
		if (total == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	endtask

	task automatic timedOut(input string what);
		otherErrors++;
		$display("Timeout: %s", what);
		finishRun();
	endtask

	task automatic nextCycle();
		@(posedge SClk);
		#2;
	endtask

	task automatic apbWrite(input logic [ApbAddrBits-1:0] addr,
		input logic [ApbDataBits-1:0] data);
		apbReq.psel = 1'b1;
		apbReq.penable = 1'b0;
		apbReq.pwrite = 1'b1;
		apbReq.paddr = addr;
		apbReq.pwdata = data;
		nextCycle();
		apbReq.penable = 1'b1;
		nextCycle();
		apbReq = '0;
	endtask

	task automatic apbRead(input logic [ApbAddrBits-1:0] addr,
		output logic [ApbDataBits-1:0] data, output logic err);
		apbReq.psel = 1'b1;
		apbReq.penable = 1'b0;
		apbReq.pwrite = 1'b0;
		apbReq.paddr = addr;
		nextCycle();
		apbReq.penable = 1'b1;
		@(negedge SClk);
		data = apbRsp.prdata;
		err = apbRsp.pslverr;
		checkFlag("APB pready", 1'b1, apbRsp.pready);
		nextCycle();
		apbReq = '0;
	endtask

	task automatic waitIdle(input string name);
		logic [ApbDataBits-1:0] status;
		logic err;
		int polls;
		polls = 0;
		apbRead(RegStatus, status, err);
		while (status[0] !== 1'b0 && polls < PollLimit)
		begin
			apbRead(RegStatus, status, err);
			polls++;
		end
		if (status[0] !== 1'b0)
			timedOut($sformatf("%s: status busy never fell", name));
	endtask

	task automatic checkQuiet(input string name, input int cycles);
		for (int i = 0; i < cycles; i++)
		begin
			@(negedge SClk);
			checkFlag($sformatf("%s bclk idle", name), 1'b0, i2sOut.bclk);
			checkFlag($sformatf("%s lrclk idle", name), 1'b0, i2sOut.lrclk);
			checkFlag($sformatf("%s rd idle", name), 1'b0, memReq.rd);
		end
		nextCycle();
	endtask

	task automatic compareStream(input string name, input logic [AddrBits-1:0] base,
		input int start);
		for (int i = start; i < rxSamples.size(); i++)
			checkSample($sformatf("%s sample %0d", name, i - start),
				expectedSample(base, i - start), rxSamples[i]);
	endtask

	task automatic startRow(input logic [AddrBits-1:0] base, input logic [LengthBits-1:0] len,
		input int latency, input int waitCycles);
		memLatency = latency;
		memWaitCycles = waitCycles;
		rowId++;
		apbWrite(RegBase, ApbDataBits'(base));
		apbWrite(RegLength, ApbDataBits'(len));
		apbWrite(RegCtrl, 32'h1);
	endtask

	task automatic runRow(input scenario_t row);
		logic [ApbDataBits-1:0] status;
		logic err;
		int start;
		start = rxSamples.size();
		startRow(row.baseAddr, row.length, row.latency, row.waitCycles);
		waitIdle(row.name);
		apbRead(RegStatus, status, err);
		checkFlag($sformatf("%s done", row.name), 1'b1, status[1]);
		checkFlag($sformatf("%s underrun", row.name), row.stall, status[2]);
		if (row.stall)
		begin
			apbWrite(RegStatus, 32'h4);
			apbRead(RegStatus, status, err);
			checkFlag($sformatf("%s underrun cleared", row.name), 1'b0, status[2]);
		end
		else
		begin
			checkWord($sformatf("%s sample count", row.name), 32'(8 * row.length),
				32'(rxSamples.size() - start));
			compareStream(row.name, row.baseAddr, start);
		end
		checkQuiet(row.name, 64);
	endtask

	// The memory model serves one request at a time
	always @(negedge SClk)
	begin
		rdSample = memReq.rd;
		addrSample = memReq.addr;
	end

	always @(posedge SClk)
	begin
		#2;
		if (reset)
		begin
			memBusy = 1'b0;
			waitLeft = 0;
			memRsp = '0;
		end
		else
		begin
			if (waitLeft > 0)
				waitLeft--;
			if (memRsp.ack)
			begin
				memRsp.ack = 1'b0;
				memBusy = 1'b0;
				waitLeft = memWaitCycles;
			end
			else if (memBusy || rdSample)
			begin
				if (!memBusy)
				begin
					memBusy = 1'b1;
					reqAddr = addrSample;
					latLeft = memLatency;
				end
				latLeft--;
				if (latLeft == 0)
				begin
					memRsp.ack = 1'b1;
					memRsp.data = wordAt(reqAddr);
				end
			end
			memRsp.memWait = (waitLeft > 0);
		end
	end

	// In the I2S receiver a new row or an lrclk change marks the delay bit of a slot
	always @(posedge bclk)
	begin
		if (rxRow != rowId || i2sOut.lrclk != prevLr)
		begin
			if (rxRow != rowId)
				rowSampleCnt = 0;
			rxRow = rowId;
			slotBit = 0;
		end
		else
			slotBit++;
		prevLr = i2sOut.lrclk;
		if (slotBit >= 1 && slotBit <= SampleBits)
		begin
			shiftReg = {shiftReg[SampleBits-2:0], i2sOut.sdata};
			if (slotBit == SampleBits)
			begin
				checkFlag($sformatf("lrclk of sample %0d", rowSampleCnt),
					logic'(rowSampleCnt % 2), i2sOut.lrclk);
				rxSamples.push_back(shiftReg);
				rowSampleCnt++;
			end
		end
	end

	initial
	begin
		logic [ApbDataBits-1:0] rdata;
		logic err;
		int waited;
		int start;
		repeat (5) @(posedge SClk);
		#2;
		reset = 1'b0;

		foreach (regList[i])
		begin
			apbRead(regList[i], rdata, err);
			checkWord($sformatf("reset value of %s", regList[i].name()), '0, rdata);
			checkFlag($sformatf("pslverr of %s", regList[i].name()), 1'b0, err);
		end
		apbWrite(RegBase, 32'h0002A5A5);
		apbWrite(RegLength, 32'h0000BEEF);
		apbRead(RegBase, rdata, err);
		checkWord("base readback", 32'h0002A5A5, rdata);
		apbRead(RegLength, rdata, err);
		checkWord("length readback", 32'h0000BEEF, rdata);
		apbRead(4'h2, rdata, err);
		checkWord("unmapped read data", '0, rdata);
		checkFlag("unmapped pslverr", 1'b1, err);

		for (int i = 0; i < NumRows; i++)
			runRow(rows[i]);

		// Stop while the fetcher is held off by a full FIFO
		start = rxSamples.size();
		startRow(22'h000040, 16'd20, 3, 1);
		waited = 0;
		while (rxSamples.size() - start < 20 && waited < CycleLimit)
		begin
			nextCycle();
			waited++;
		end
		if (rxSamples.size() - start < 20)
			timedOut("stop: samples before the stop did not arrive");
		apbWrite(RegCtrl, 32'h2);
		waitIdle("stop");
		waited = 0;
		@(negedge SClk);
		while (memReq.rd !== 1'b0 && waited < 100)
		begin
			@(negedge SClk);
			waited++;
		end
		if (memReq.rd !== 1'b0)
			timedOut("stop: open memory read never completed");
		nextCycle();
		compareStream("stop", 22'h000040, start);
		checkQuiet("stop", 200);

		finishRun();
	end

endmodule

`default_nettype wire

// File: sources.f
apbPkg.sv
audioPkg.sv
apbRegs.sv
sampleFetcher.sv
sampleFifo.sv
i2sSerializer.sv
i2sPlayer.sv
i2sPlayer_properties.sv
i2sPlayerTb.sv

// File: Bender.yml
package:
  name: i2s_player

sources:
  - apbPkg.sv
  - audioPkg.sv
  - apbRegs.sv
  - sampleFetcher.sv
  - sampleFifo.sv
  - i2sSerializer.sv
  - i2sPlayer.sv
  - target: test
    files:
      - i2sPlayer_properties.sv
      - i2sPlayerTb.sv
